// File: logic/phivers_params.svh
`ifndef PHIVERS_PARAMS_SVH
`define PHIVERS_PARAMS_SVH

// Flit and source word width.
`define FLIT_W 32

// NoC address width, {x, y}.
`define ADDR_W 16

// Largest payload one message may carry.
`define MAX_PAYLOAD_WORDS 32

// Source identifiers placed in the header flit.
`define MA_INJ_ID 8'h01
`define APP_INJ_ID 8'h02

`endif

// File: logic/noc_pkg.sv
`include "phivers_params.svh"

package noc_pkg;

    // One flit on the link, also one source word.
    typedef logic [`FLIT_W-1:0] flit_t;

    typedef enum logic [7:0] {
        SVC_TASK_LOAD = 8'h10,
        SVC_APP_DESCR = 8'h20,
        SVC_APP_END   = 8'h21
    } inj_service_e;

    typedef struct packed {
        inj_service_e       service;    // Service code, top byte.
        logic [7:0]         source_id;  // Injector identifier.
        logic [`ADDR_W-1:0] target;     // Destination router address.
    } inj_header_s;

    // Header is written as fields and sent as a raw flit.
    typedef union packed {
        flit_t       raw;
        inj_header_s fields;
    } inj_header_u;

endpackage

// File: logic/noc_link_if.sv
`timescale 1ns/1ps

interface noc_link_if
    import noc_pkg::*;
();

    logic  tx;      // Flit valid.
    logic  eop;     // Last flit of the packet.
    flit_t data;
    logic  credit;  // Receiver can take the flit.

    modport sender (
        output tx,
        output eop,
        output data,
        input  credit
    );

    modport receiver (
        input  tx,
        input  eop,
        input  data,
        output credit
    );

endinterface

// File: logic/task_injector.sv
`timescale 1ns/1ps
`include "phivers_params.svh"

module task_injector
    import noc_pkg::*;
#(
    parameter logic [7:0]   SOURCE_ID = `MA_INJ_ID,
    parameter inj_service_e SERVICE   = SVC_TASK_LOAD
)
(
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               src_eoa_i,
    input  logic               src_rx_i,
    output logic               src_credit_o,
    input  flit_t              src_data_i,
    input  logic [`ADDR_W-1:0] mapper_address_i,
    noc_link_if.sender         link_o
);

    localparam int LEN_W = $clog2(`MAX_PAYLOAD_WORDS + 1);
    localparam int IDX_W = $clog2(`MAX_PAYLOAD_WORDS);

    typedef enum logic [2:0] {
        S_LEN,
        S_PAYLOAD,
        S_HEADER,
        S_LENGTH,
        S_DATA
    } state_e;

    state_e           state_q;
    logic [LEN_W-1:0] len_q;
    logic [IDX_W-1:0] idx_q;      // Write index while collecting, read index while sending.
    logic             end_q;      // Current packet is the end-of-application mark.
    flit_t            payload_q [`MAX_PAYLOAD_WORDS];
    inj_header_u      header;
    logic             last_word;
    logic             src_take;
    logic             xfer;

    assign src_credit_o = (state_q == S_LEN) || (state_q == S_PAYLOAD);
    assign src_take     = src_rx_i && src_credit_o;
    assign xfer         = link_o.tx && link_o.credit;
    assign last_word    = (LEN_W'(idx_q) + LEN_W'(1)) == len_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= S_LEN;
            len_q   <= '0;
            idx_q   <= '0;
            end_q   <= 1'b0;
        end else begin
            case (state_q)
                S_LEN: begin
                    idx_q <= '0;
                    if (src_take) begin
                        len_q   <= src_data_i[LEN_W-1:0];
                        end_q   <= 1'b0;
                        state_q <= S_PAYLOAD;
                    end else if (src_eoa_i) begin
                        end_q   <= 1'b1;   // Two-flit end packet, no payload.
                        state_q <= S_HEADER;
                    end
                end
                S_PAYLOAD: begin
                    if (src_take) begin
                        idx_q <= idx_q + 1'b1;
                        if (last_word) begin
                            state_q <= S_HEADER;
                        end
                    end
                end
                S_HEADER: begin
                    if (xfer) begin
                        state_q <= S_LENGTH;
                    end
                end
                S_LENGTH: begin
                    if (xfer) begin
                        idx_q   <= '0;
                        state_q <= end_q ? S_LEN : S_DATA;
                    end
                end
                S_DATA: begin
                    if (xfer) begin
                        idx_q <= idx_q + 1'b1;
                        if (last_word) begin
                            state_q <= S_LEN;
                        end
                    end
                end
                default: begin
                    state_q <= S_LEN;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == S_PAYLOAD && src_take) begin
            payload_q[idx_q] <= src_data_i;
        end
    end

    always_comb begin
        header.fields.service   = end_q ? SVC_APP_END : SERVICE;
        header.fields.source_id = SOURCE_ID;
        header.fields.target    = mapper_address_i;
    end

    always_comb begin
        link_o.tx   = 1'b0;
        link_o.eop  = 1'b0;
        link_o.data = header.raw;
        case (state_q)
            S_HEADER: begin
                link_o.tx = 1'b1;
            end
            S_LENGTH: begin
                link_o.tx   = 1'b1;
                link_o.eop  = end_q;
                link_o.data = end_q ? '0 : flit_t'(len_q);
            end
            S_DATA: begin
                link_o.tx   = 1'b1;
                link_o.eop  = last_word;
                link_o.data = payload_q[idx_q];
            end
            default: begin
                link_o.tx = 1'b0;
            end
        endcase
    end

    a_len_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (state_q == S_LEN && src_take) |->
            (src_data_i >= 1 && src_data_i <= `MAX_PAYLOAD_WORDS))
        else $error("task_injector: length word %0h out of range", src_data_i);

    a_eop_tx: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        link_o.eop |-> link_o.tx)
        else $error("task_injector: eop without tx");

    // Flit must hold until the receiver gives credit.
    a_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (link_o.tx && !link_o.credit) |=>
            (link_o.tx && $stable(link_o.data) && $stable(link_o.eop)))
        else $error("task_injector: flit changed under back-pressure");

endmodule

// File: logic/link_arbiter.sv
`timescale 1ns/1ps

module link_arbiter
    import noc_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic         release_i,
    noc_link_if.receiver ma_link_i,
    noc_link_if.receiver app_link_i,
    output logic         noc_tx_o,
    output logic         noc_eop_o,
    output flit_t        noc_data_o,
    input  logic         noc_credit_i
);

    logic [1:0] grant_q;      // Bit 0 mapper, bit 1 application.
    logic [1:0] grant_new;
    logic [1:0] grant;
    logic       last_app_q;   // Last packet went to the application side.
    logic       req_ma;
    logic       req_app;
    logic       busy;
    logic       xfer;

    assign req_ma  = ma_link_i.tx;
    assign req_app = app_link_i.tx && release_i;   // App only competes while released.
    assign busy    = |grant_q;
    assign xfer    = noc_tx_o && noc_credit_i;

    always_comb begin
        grant_new = 2'b00;
        if (req_ma && req_app) begin
            grant_new = last_app_q ? 2'b01 : 2'b10;
        end else if (req_ma) begin
            grant_new = 2'b01;
        end else if (req_app) begin
            grant_new = 2'b10;
        end
        grant = busy ? grant_q : grant_new;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            grant_q    <= 2'b00;
            last_app_q <= 1'b0;
        end else begin
            if (xfer && noc_eop_o) begin
                grant_q <= 2'b00;
            end else begin
                grant_q <= grant;   // Lock once shown, even before the header moves.
            end
            if (!busy && (|grant_new)) begin
                last_app_q <= grant_new[1];
            end
        end
    end

    always_comb begin
        noc_tx_o   = 1'b0;
        noc_eop_o  = 1'b0;
        noc_data_o = ma_link_i.data;
        if (grant[0]) begin
            noc_tx_o  = ma_link_i.tx;
            noc_eop_o = ma_link_i.eop;
        end else if (grant[1]) begin
            noc_tx_o   = app_link_i.tx;
            noc_eop_o  = app_link_i.eop;
            noc_data_o = app_link_i.data;
        end
    end

    assign ma_link_i.credit  = grant[0] && noc_credit_i;
    assign app_link_i.credit = grant[1] && noc_credit_i;

    a_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(grant))
        else $error("link_arbiter: grant %b not one-hot", grant);

    // Held from the first shown flit up to the eop transfer.
    a_grant_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (noc_tx_o && !(noc_credit_i && noc_eop_o)) |=> (grant == $past(grant)))
        else $error("link_arbiter: grant changed inside a packet");

endmodule

// File: logic/phivers_io.sv
`timescale 1ns/1ps
`include "phivers_params.svh"

module phivers_io
    import noc_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_n_i,

    input  logic [`ADDR_W-1:0] mapper_address_i,
    input  logic               release_i,

    input  logic               ma_src_rx_i,
    output logic               ma_src_credit_o,
    input  flit_t              ma_src_data_i,

    input  logic               app_src_eoa_i,
    input  logic               app_src_rx_i,
    output logic               app_src_credit_o,
    input  flit_t              app_src_data_i,

    output logic               noc_tx_o,
    output logic               noc_eop_o,
    input  logic               noc_credit_i,
    output flit_t              noc_data_o
);

    noc_link_if ma_link ();
    noc_link_if app_link ();

    task_injector #(
        .SOURCE_ID (`MA_INJ_ID    ),
        .SERVICE   (SVC_TASK_LOAD )
    )
    ma_injector (
        .clk_i            (clk_i           ),
        .rst_n_i          (rst_n_i         ),
        .src_eoa_i        (1'b0            ),   // Mapper never ends an application.
        .src_rx_i         (ma_src_rx_i     ),
        .src_credit_o     (ma_src_credit_o ),
        .src_data_i       (ma_src_data_i   ),
        .mapper_address_i (mapper_address_i),
        .link_o           (ma_link         )
    );

    task_injector #(
        .SOURCE_ID (`APP_INJ_ID   ),
        .SERVICE   (SVC_APP_DESCR )
    )
    app_injector (
        .clk_i            (clk_i           ),
        .rst_n_i          (rst_n_i         ),
        .src_eoa_i        (app_src_eoa_i   ),
        .src_rx_i         (app_src_rx_i    ),
        .src_credit_o     (app_src_credit_o),
        .src_data_i       (app_src_data_i  ),
        .mapper_address_i (mapper_address_i),
        .link_o           (app_link        )
    );

    link_arbiter arbiter (
        .clk_i        (clk_i       ),
        .rst_n_i      (rst_n_i     ),
        .release_i    (release_i   ),
        .ma_link_i    (ma_link     ),
        .app_link_i   (app_link    ),
        .noc_tx_o     (noc_tx_o    ),
        .noc_eop_o    (noc_eop_o   ),
        .noc_data_o   (noc_data_o  ),
        .noc_credit_i (noc_credit_i)
    );

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 10
)
(
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;   // Released between edges.
    end

endmodule

// File: verification/tb_phivers_io.sv
`timescale 1ns/1ps
`include "phivers_params.svh"

module tb_phivers_io
    import noc_pkg::*;
();

    localparam int          DEPTH    = 1024;
    localparam int          MA_MSGS  = 24;
    localparam int          APP_MSGS = 20;
    localparam int          OWN_MA   = 0;
    localparam int          OWN_APP  = 1;
    localparam int          OWN_NONE = 2;
    localparam logic [31:0] SEED     = 32'h45749ea2;

    logic               clk;
    logic               rst_n;
    logic [`ADDR_W-1:0] mapper_addr;
    logic               release_lvl;
    logic               src_rx [2];
    flit_t              src_data [2];
    logic               src_last [2];   // Word driven now closes a message.
    logic               src_credit [2];
    logic               app_eoa;
    logic               noc_tx;
    logic               noc_eop;
    logic               noc_credit;
    flit_t              noc_data;

    flit_t       stim_word [2][DEPTH];
    logic        stim_last [2][DEPTH];
    logic        stim_eoa [2][DEPTH];
    int          stim_cnt [2] = '{0, 0};
    flit_t       exp_word [2][DEPTH];
    logic        exp_last [2][DEPTH];
    int          exp_wr [2] = '{0, 0};
    int          exp_rd [2] = '{0, 0};
    flit_t       head_data [2];
    logic        head_eop [2];
    logic        head_valid [2];
    int          owner_q = OWN_NONE;
    int          last_owner_q = OWN_MA;   // Arbiter favours the application side first.
    int          cur_owner;
    int          errors = 0;
    int          flits_seen = 0;
    int          packets_seen = 0;
    int          total_flits = 0;
    logic [31:0] build_rng;

    tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(10)) clock_gen (.clk_o(clk), .rst_n_o(rst_n));

    phivers_io phivers_io_inst (
        .clk_i            (clk          ),
        .rst_n_i          (rst_n        ),
        .mapper_address_i (mapper_addr  ),
        .release_i        (release_lvl  ),
        .ma_src_rx_i      (src_rx[0]    ),
        .ma_src_credit_o  (src_credit[0]),
        .ma_src_data_i    (src_data[0]  ),
        .app_src_eoa_i    (app_eoa      ),
        .app_src_rx_i     (src_rx[1]    ),
        .app_src_credit_o (src_credit[1]),
        .app_src_data_i   (src_data[1]  ),
        .noc_tx_o         (noc_tx       ),
        .noc_eop_o        (noc_eop      ),
        .noc_credit_i     (noc_credit   ),
        .noc_data_o       (noc_data     )
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int pick(input logic [31:0] s, input int n);
        return int'(s[30:16]) % n;
    endfunction

    task automatic add_stim(input int src, input flit_t w, input logic last, input logic eoa);
        stim_word[src][stim_cnt[src]] = w;
        stim_last[src][stim_cnt[src]] = last;
        stim_eoa[src][stim_cnt[src]]  = eoa;
        stim_cnt[src] = stim_cnt[src] + 1;
    endtask

    task automatic add_expect(input int src, input flit_t w, input logic eop);
        exp_word[src][exp_wr[src]] = w;
        exp_last[src][exp_wr[src]] = eop;
        exp_wr[src] = exp_wr[src] + 1;
        total_flits = total_flits + 1;
    endtask

    // Header, length, then payload; eop on the last payload flit.
    task automatic push_message(input int src, input int len);
        flit_t hdr;
        flit_t w;
        hdr = (src == OWN_MA) ? flit_t'({SVC_TASK_LOAD, `MA_INJ_ID, mapper_addr})
                              : flit_t'({SVC_APP_DESCR, `APP_INJ_ID, mapper_addr});
        add_stim(src, flit_t'(len), 1'b0, 1'b0);
        add_expect(src, hdr, 1'b0);
        add_expect(src, flit_t'(len), 1'b0);
        for (int i = 0; i < len; i++) begin
            build_rng = lcg_next(build_rng);
            w = build_rng;
            add_stim(src, w, i == len - 1, 1'b0);
            add_expect(src, w, i == len - 1);
        end
    endtask

    task automatic push_end();
        add_stim(OWN_APP, '0, 1'b1, 1'b1);
        add_expect(OWN_APP, flit_t'({SVC_APP_END, `APP_INJ_ID, mapper_addr}), 1'b0);
        add_expect(OWN_APP, '0, 1'b1);
    endtask

    task automatic build_streams();
        for (int m = 0; m < MA_MSGS; m++) begin
            build_rng = lcg_next(build_rng);
            push_message(OWN_MA, (m == 0) ? `MAX_PAYLOAD_WORDS : 1 + pick(build_rng, 32));
        end
        for (int k = 0; k < APP_MSGS; k++) begin
            build_rng = lcg_next(build_rng);
            if (k % 5 == 3) begin
                push_end();
            end else begin
                push_message(OWN_APP, (k == 0) ? 1 : 1 + pick(build_rng, 32));
            end
        end
    endtask

    task automatic drive_source(input int src);
        logic [31:0] rng;
        int          pos;
        int          gap;
        rng = SEED ^ (32'h9e3779b9 + 32'(src));
        pos = 0;
        gap = 0;
        while (pos < stim_cnt[src]) begin
            @(negedge clk);
            rng = lcg_next(rng);
            src_rx[src]   = 1'b0;
            src_last[src] = 1'b0;
            if (src == OWN_APP) begin
                app_eoa = 1'b0;
            end
            if (gap > 0) begin
                gap = gap - 1;
            end else if (src_credit[src] && pick(rng, 5) != 0) begin
                if (stim_eoa[src][pos]) begin
                    app_eoa = 1'b1;   // Injector sits idle between messages here.
                end else begin
                    src_rx[src]   = 1'b1;
                    src_data[src] = stim_word[src][pos];
                end
                src_last[src] = stim_last[src][pos];
                if (stim_last[src][pos]) begin
                    rng = lcg_next(rng);
                    gap = pick(rng, 8);
                end
                pos = pos + 1;
            end
        end
        @(negedge clk);
        src_rx[src]   = 1'b0;
        src_last[src] = 1'b0;
        if (src == OWN_APP) begin
            app_eoa = 1'b0;
        end
    endtask

    task automatic drive_credit();
        logic [31:0] rng;
        rng = SEED ^ 32'h0000c3d1;
        forever begin
            @(negedge clk);
            rng = lcg_next(rng);
            noc_credit = pick(rng, 4) != 0;
        end
    endtask

    task automatic drive_release();
        logic [31:0] rng;
        rng = SEED ^ 32'h00a5a500;
        forever begin
            rng = lcg_next(rng);
            release_lvl = 1'b1;
            repeat (20 + pick(rng, 80)) @(negedge clk);
            rng = lcg_next(rng);
            release_lvl = 1'b0;
            repeat (10 + pick(rng, 50)) @(negedge clk);
        end
    endtask

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            head_valid[s] = exp_rd[s] < exp_wr[s];
            head_data[s]  = exp_word[s][exp_rd[s]];
            head_eop[s]   = exp_last[s][exp_rd[s]];
        end
        if (owner_q != OWN_NONE) begin
            cur_owner = owner_q;
        end else if (head_valid[OWN_APP] && noc_data == head_data[OWN_APP]) begin
            cur_owner = OWN_APP;
        end else begin
            cur_owner = OWN_MA;
        end
    end

    always @(posedge clk) begin
        if (rst_n && noc_tx) begin
            if (owner_q == OWN_NONE) begin
                last_owner_q <= cur_owner;
            end
            owner_q <= cur_owner;
            if (noc_credit) begin
                exp_rd[cur_owner] <= exp_rd[cur_owner] + 1;
                flits_seen        <= flits_seen + 1;
                if (noc_eop) begin
                    owner_q      <= OWN_NONE;
                    packets_seen <= packets_seen + 1;
                end
            end
        end
    end

    a_header_known: assert property (@(posedge clk) disable iff (!rst_n)
        (noc_tx && owner_q == OWN_NONE) |->
            ((head_valid[OWN_MA] && noc_data == head_data[OWN_MA]) ||
             (head_valid[OWN_APP] && noc_data == head_data[OWN_APP])))
        else begin
            errors++;
            $display("** Error: noc_data_o = %h, expected header %h or %h", $sampled(noc_data),
                     $sampled(head_data[OWN_MA]), $sampled(head_data[OWN_APP]));
        end

    a_ma_flit: assert property (@(posedge clk) disable iff (!rst_n)
        (noc_tx && noc_credit && cur_owner == OWN_MA) |->
            (head_valid[OWN_MA] && noc_data == head_data[OWN_MA] && noc_eop == head_eop[OWN_MA]))
        else begin
            errors++;
            $display("** Error: mapper noc_data_o = %h, noc_eop_o = %h, expected %h, %h",
                     $sampled(noc_data), $sampled(noc_eop),
                     $sampled(head_data[OWN_MA]), $sampled(head_eop[OWN_MA]));
        end

    a_app_flit: assert property (@(posedge clk) disable iff (!rst_n)
        (noc_tx && noc_credit && cur_owner == OWN_APP) |->
            (head_valid[OWN_APP] && noc_data == head_data[OWN_APP] &&
             noc_eop == head_eop[OWN_APP]))
        else begin
            errors++;
            $display("** Error: application noc_data_o = %h, noc_eop_o = %h, expected %h, %h",
                     $sampled(noc_data), $sampled(noc_eop),
                     $sampled(head_data[OWN_APP]), $sampled(head_eop[OWN_APP]));
        end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (noc_tx && !noc_credit) |=> (noc_tx && $stable(noc_data) && $stable(noc_eop)))
        else begin
            errors++;
            $display("** Error: noc_data_o = %h, noc_eop_o = %h changed while stalled",
                     $sampled(noc_data), $sampled(noc_eop));
        end

    a_release_gate: assert property (@(posedge clk) disable iff (!rst_n)
        (noc_tx && owner_q == OWN_NONE && cur_owner == OWN_APP) |-> release_lvl)
        else begin
            errors++;
            $display("An application header started on noc_tx_o while release_i was low");
        end

    // Both injectors wait with a complete message when their credits are low.
    a_alternate: assert property (@(posedge clk) disable iff (!rst_n)
        (noc_tx && owner_q == OWN_NONE && !src_credit[0] && !src_credit[1] && release_lvl) |->
            (cur_owner != last_owner_q))
        else begin
            errors++;
            $display("The same source was granted twice in a row while both were pending");
        end

    a_reset_state: assert property (@(posedge clk)
        !$past(rst_n) |-> (!noc_tx && !noc_eop && src_credit[0] && src_credit[1]))
        else begin
            errors++;
            $display("** Error: reset state noc_tx_o = %h, noc_eop_o = %h, credits = %h %h",
                     $sampled(noc_tx), $sampled(noc_eop),
                     $sampled(src_credit[0]), $sampled(src_credit[1]));
        end

    a_ma_credit_drop: assert property (@(posedge clk) disable iff (!rst_n)
        (src_last[0] && src_rx[0] && src_credit[0]) |=> !src_credit[0])
        else begin
            errors++;
            $display("Mapper source credit stayed high after the last word of a message");
        end

    a_app_credit_drop: assert property (@(posedge clk) disable iff (!rst_n)
        (src_last[1] && (src_rx[1] || app_eoa) && src_credit[1]) |=> !src_credit[1])
        else begin
            errors++;
            $display("Application source credit stayed high after a complete message");
        end

    a_ma_credit_back: assert property (@(posedge clk) disable iff (!rst_n)
        (noc_tx && noc_credit && noc_eop && cur_owner == OWN_MA) |=> src_credit[0])
        else begin
            errors++;
            $display("Mapper source credit did not return after the eop transfer");
        end

    a_app_credit_back: assert property (@(posedge clk) disable iff (!rst_n)
        (noc_tx && noc_credit && noc_eop && cur_owner == OWN_APP) |=> src_credit[1])
        else begin
            errors++;
            $display("Application source credit did not return after the eop transfer");
        end

    initial begin
        release_lvl = 1'b0;
        src_rx      = '{1'b0, 1'b0};
        src_data    = '{'0, '0};
        src_last    = '{1'b0, 1'b0};
        app_eoa     = 1'b0;
        noc_credit  = 1'b0;
        build_rng   = SEED;
        mapper_addr = build_rng[23:8];
        build_rng   = lcg_next(build_rng);
        build_streams();
        fork
            begin
                repeat (total_flits * 20 + 2000) @(posedge clk);
                $display("Timeout: not all expected flits arrived on the NoC link");
                $display("Regression failed");
                $finish;
            end
        join_none
        wait (rst_n);
        fork
            drive_credit();
            drive_release();
        join_none
        fork
            drive_source(OWN_MA);
            drive_source(OWN_APP);
        join
        wait (exp_rd[0] == exp_wr[0] && exp_rd[1] == exp_wr[1]);
        repeat (10) @(negedge clk);   // Trailing flits would show up here.
        $display("Checked %0d of %0d flits in %0d packets, errors: %0d",
                 flits_seen, total_flits, packets_seen, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+logic
logic/noc_pkg.sv
logic/noc_link_if.sv
logic/task_injector.sv
logic/link_arbiter.sv
logic/phivers_io.sv
verification/tb_clock_gen.sv
verification/tb_phivers_io.sv

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_phivers_io \
    -f project.f \
    -o sim_phivers_io

./obj_dir/sim_phivers_io 2>&1 | tee sim.log

if grep -q "Regression failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi

echo "Simulation finished, see sim.log"
